//--- rv_decode.f
rv_decode_pkg.sv
rv_imm_gen.sv
rv_op_decoder.sv
rv_decode_stage.sv
rv_op_fifo.sv
rv_issue_port.sv
rv_decode_top.sv
tb_clk_gen.sv
tb_rv_decode.sv

//--- Bender.yml
package:
  name: rv_decode

sources:
  - rv_decode_pkg.sv
  - rv_imm_gen.sv
  - rv_op_decoder.sv
  - rv_decode_stage.sv
  - rv_op_fifo.sv
  - rv_issue_port.sv
  - rv_decode_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_rv_decode.sv

//--- tb_rv_decode.sv
`default_nettype none

module tb_rv_decode;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int fifo_depth = 4;
	localparam int timeout_cycles = 200;
	localparam int stall_cycles = 20;

	logic clk_i;
	logic rst_n;
	rv_decode_pkg::inst_word_u inst = '0;
	logic inst_req = 1'b0;
	logic inst_ack;
	rv_decode_pkg::dec_op_t op;
	logic op_req;
	logic op_ack = 1'b0;

	integer seed;
	logic hold_ack = 1'b0;
	logic op_req_q = 1'b0;
	int ack_delay = 0;
	logic [31:0] word_q[$];
	rv_decode_pkg::dec_op_t exp_q[$];
	logic [31:0] cur_word = '0;
	bit hung = 1'b0;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int test_errors = 0;
	int test_words = 0;
	int recv_count = 0;

	tb_clk_gen u_clk_gen (
		.clk_i (clk_i),
		.rst_n (rst_n)
	);

	rv_decode_top #(
		.FIFO_DEPTH (fifo_depth)
	) dut (
		.clk_i    (clk_i),
		.rst_n    (rst_n),
		.inst     (inst),
		.inst_req (inst_req),
		.inst_ack (inst_ack),
		.op       (op),
		.op_req   (op_req),
		.op_ack   (op_ack)
	);

	// alt picks the funct7 bit 5 variant sub or sra
	function automatic rv_decode_pkg::alu_op_e base_alu(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0: return alt ? rv_decode_pkg::alu_sub : rv_decode_pkg::alu_add;
			3'd1: return rv_decode_pkg::alu_sll;
			3'd2: return rv_decode_pkg::alu_slt;
			3'd3: return rv_decode_pkg::alu_sltu;
			3'd4: return rv_decode_pkg::alu_xor;
			3'd5: return alt ? rv_decode_pkg::alu_sra : rv_decode_pkg::alu_srl;
			3'd6: return rv_decode_pkg::alu_or;
			default: return rv_decode_pkg::alu_and;
		endcase
	endfunction

	function automatic rv_decode_pkg::dec_op_t decode_ref(input logic [31:0] w);
		rv_decode_pkg::dec_op_t r;
		logic [6:0] f7;
		logic [2:0] f3;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		r = '0;
		f7 = w[31:25];
		f3 = w[14:12];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		imm_u = {w[31:12], 12'b0};
		imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		case (w[6:0])
			rv_decode_pkg::opc_op_imm: begin
				r.rs1 = w[19:15];
				r.rd_wen = 1'b1;
				r.alu_src_imm = 1'b1;
				r.wb_sel = rv_decode_pkg::wb_alu;
				r.alu_op = base_alu(f3, f3 == 3'd5 && f7[5]);
				r.imm = imm_i;
				if (f3 == 3'd1 || f3 == 3'd5) begin
					r.imm = {26'b0, w[25:20]};
					r.illegal = !(f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20));
				end
			end
			rv_decode_pkg::opc_op: begin
				r.rs1 = w[19:15];
				r.rs2 = w[24:20];
				r.rd_wen = 1'b1;
				r.wb_sel = rv_decode_pkg::wb_alu;
				r.illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
				if (!r.illegal) r.alu_op = base_alu(f3, f7[5]);
			end
			rv_decode_pkg::opc_load: begin
				r.rs1 = w[19:15];
				r.alu_src_imm = 1'b1;
				r.imm = imm_i;
				r.illegal = !(f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd2 || f3 == 3'd4 || f3 == 3'd5);
				if (!r.illegal) begin
					r.rd_wen = 1'b1;
					r.mem_kind = rv_decode_pkg::mem_load;
					r.mem_unsigned = f3[2];
					r.wb_sel = rv_decode_pkg::wb_mem;
				end
			end
			rv_decode_pkg::opc_store: begin
				r.rs1 = w[19:15];
				r.rs2 = w[24:20];
				r.alu_src_imm = 1'b1;
				r.imm = imm_s;
				r.illegal = f3 > 3'd2;
				if (!r.illegal) r.mem_kind = rv_decode_pkg::mem_store;
			end
			rv_decode_pkg::opc_branch: begin
				r.rs1 = w[19:15];
				r.rs2 = w[24:20];
				r.imm = imm_b;
				case (f3)
					3'd0: r.br_cond = rv_decode_pkg::br_eq;
					3'd1: r.br_cond = rv_decode_pkg::br_ne;
					3'd4: r.br_cond = rv_decode_pkg::br_lt;
					3'd5: r.br_cond = rv_decode_pkg::br_ge;
					3'd6: r.br_cond = rv_decode_pkg::br_ltu;
					3'd7: r.br_cond = rv_decode_pkg::br_geu;
					default: r.illegal = 1'b1;
				endcase
				// equality compares by subtraction
				if (f3 == 3'd4 || f3 == 3'd5) r.alu_op = rv_decode_pkg::alu_slt;
				else if (f3 == 3'd6 || f3 == 3'd7) r.alu_op = rv_decode_pkg::alu_sltu;
				else if (!r.illegal) r.alu_op = rv_decode_pkg::alu_sub;
			end
			rv_decode_pkg::opc_jal: begin
				r.rd_wen = 1'b1;
				r.jump = rv_decode_pkg::jump_jal;
				r.wb_sel = rv_decode_pkg::wb_pc4;
				r.imm = imm_j;
			end
			rv_decode_pkg::opc_jalr: begin
				r.rs1 = w[19:15];
				r.alu_src_imm = 1'b1;
				r.imm = imm_i;
				r.illegal = f3 != 3'd0;
				if (!r.illegal) begin
					r.rd_wen = 1'b1;
					r.jump = rv_decode_pkg::jump_jalr;
					r.wb_sel = rv_decode_pkg::wb_pc4;
				end
			end
			rv_decode_pkg::opc_lui, rv_decode_pkg::opc_auipc: begin
				r.rd_wen = 1'b1;
				r.imm = imm_u;
				r.wb_sel = w[5] ? rv_decode_pkg::wb_imm : rv_decode_pkg::wb_pc_imm;
			end
			rv_decode_pkg::opc_system: begin
				r.trap = (w == 32'h0010_0073);
				r.illegal = !r.trap;
			end
			default: r.illegal = 1'b1;
		endcase
		if (r.mem_kind != rv_decode_pkg::mem_none) begin
			case (f3[1:0])
				2'd0: r.mem_size = rv_decode_pkg::size_byte;
				2'd1: r.mem_size = rv_decode_pkg::size_half;
				default: r.mem_size = rv_decode_pkg::size_word;
			endcase
		end
		if (r.illegal) r.rd_wen = 1'b0;
		if (r.rd_wen) r.rd = w[11:7];
		return r;
	endfunction

	function automatic bit known_opcode(input logic [6:0] opc);
		case (opc)
			rv_decode_pkg::opc_load, rv_decode_pkg::opc_op_imm, rv_decode_pkg::opc_auipc,
			rv_decode_pkg::opc_store, rv_decode_pkg::opc_op, rv_decode_pkg::opc_lui,
			rv_decode_pkg::opc_branch, rv_decode_pkg::opc_jalr, rv_decode_pkg::opc_jal,
			rv_decode_pkg::opc_system: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] %0t ns word %h: %s got %h expected %h", $time, cur_word, what, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic compare_record();
		rv_decode_pkg::dec_op_t e;
		if (exp_q.size() == 0) begin
			$display("a record came out at %0t ns with no word waiting for it", $time);
			errors++;
			test_errors++;
			return;
		end
		cur_word = word_q.pop_front();
		e = exp_q.pop_front();
		recv_count++;
		check_val("rs1", op.rs1, e.rs1);
		check_val("rs2", op.rs2, e.rs2);
		check_val("rd", op.rd, e.rd);
		check_val("rd_wen", op.rd_wen, e.rd_wen);
		check_val("alu_op", op.alu_op, e.alu_op);
		check_val("alu_src_imm", op.alu_src_imm, e.alu_src_imm);
		check_val("imm", op.imm, e.imm);
		check_val("mem_kind", op.mem_kind, e.mem_kind);
		check_val("mem_size", op.mem_size, e.mem_size);
		check_val("mem_unsigned", op.mem_unsigned, e.mem_unsigned);
		check_val("br_cond", op.br_cond, e.br_cond);
		check_val("jump", op.jump, e.jump);
		check_val("wb_sel", op.wb_sel, e.wb_sel);
		check_val("trap", op.trap, e.trap);
		check_val("illegal", op.illegal, e.illegal);
	endtask

	// record is stable while op_req is high
	always @(posedge clk_i) begin
		op_req_q <= op_req;
		if (rst_n === 1'b1 && op_req && !op_req_q) compare_record();
	end

	// sink answers each request after 0 to 5 cycles
	always @(posedge clk_i) begin
		if (!rst_n) begin
			op_ack <= 1'b0;
			ack_delay <= 0;
		end else if (op_ack) begin
			if (!op_req) begin
				op_ack <= 1'b0;
				ack_delay <= $unsigned($random(seed)) % 6;
			end
		end else if (op_req && !hold_ack) begin
			if (ack_delay == 0) op_ack <= 1'b1;
			else ack_delay <= ack_delay - 1;
		end
	end

	task automatic wait_ack(input logic level, input string what);
		int n;
		n = 0;
		if (hung) return;
		while (inst_ack !== level && n < timeout_cycles) begin
			@(posedge clk_i);
			n++;
		end
		if (inst_ack !== level) begin
			$display("timeout: inst_ack never went to %0d while %s", level, what);
			hung = 1'b1;
		end
	endtask

	task automatic send_word(input logic [31:0] w);
		if (hung) return;
		word_q.push_back(w);
		exp_q.push_back(decode_ref(w));
		test_words++;
		wait_ack(1'b0, "waiting to send");
		@(posedge clk_i);
		inst <= w;
		inst_req <= 1'b1;
		wait_ack(1'b1, "waiting for the acknowledge");
		inst_req <= 1'b0;
		wait_ack(1'b0, "waiting for the release");
	endtask

	// negative f3 or f7 keeps the random bits
	task automatic send_rand(input logic [6:0] opc, input int f3, input int f7);
		logic [31:0] w;
		w = $random(seed);
		if (f3 >= 0) w[14:12] = f3[2:0];
		if (f7 >= 0) w[31:25] = f7[6:0];
		w[6:0] = opc;
		send_word(w);
	endtask

	task automatic drain(input string name);
		int n;
		n = 0;
		if (hung) return;
		while ((exp_q.size() != 0 || op_req || op_ack) && n < timeout_cycles) begin
			@(posedge clk_i);
			n++;
		end
		if (exp_q.size() != 0 || op_req || op_ack) begin
			$display("timeout: %0d records of test %s never came out", exp_q.size(), name);
			hung = 1'b1;
		end
	endtask

	task automatic begin_test();
		test_errors = 0;
		test_words = 0;
	endtask

	task automatic end_test(input string name);
		drain(name);
		tests_run++;
		$display("test %s: %0d words, %0d errors", name, test_words, test_errors);
	endtask

	task automatic reg_reg_alu();
		begin_test();
		for (int rep = 0; rep < 2; rep++) begin
			for (int f3 = 0; f3 < 8; f3++) send_rand(rv_decode_pkg::opc_op, f3, 7'h00);
			send_rand(rv_decode_pkg::opc_op, 0, 7'h20);
			send_rand(rv_decode_pkg::opc_op, 5, 7'h20);
		end
		end_test("reg-reg");
	endtask

	task automatic imm_alu();
		begin_test();
		for (int rep = 0; rep < 3; rep++) begin
			send_rand(rv_decode_pkg::opc_op_imm, 0, -1);
			send_rand(rv_decode_pkg::opc_op_imm, 2, -1);
			send_rand(rv_decode_pkg::opc_op_imm, 3, -1);
			send_rand(rv_decode_pkg::opc_op_imm, 4, -1);
			send_rand(rv_decode_pkg::opc_op_imm, 6, -1);
			send_rand(rv_decode_pkg::opc_op_imm, 7, -1);
		end
		send_rand(rv_decode_pkg::opc_op_imm, 1, 7'h00);
		send_rand(rv_decode_pkg::opc_op_imm, 5, 7'h00);
		send_rand(rv_decode_pkg::opc_op_imm, 5, 7'h20);
		// bad funct7 on shifts
		send_rand(rv_decode_pkg::opc_op_imm, 1, 7'h20);
		send_rand(rv_decode_pkg::opc_op_imm, 5, 7'h01);
		end_test("imm-alu");
	endtask

	task automatic memory_access();
		begin_test();
		for (int rep = 0; rep < 2; rep++) begin
			for (int f3 = 0; f3 < 6; f3++) begin
				if (f3 != 3) send_rand(rv_decode_pkg::opc_load, f3, -1);
			end
			for (int f3 = 0; f3 < 3; f3++) send_rand(rv_decode_pkg::opc_store, f3, -1);
		end
		end_test("memory");
	endtask

	task automatic control_flow();
		begin_test();
		for (int rep = 0; rep < 2; rep++) begin
			for (int f3 = 0; f3 < 8; f3++) begin
				if (f3 != 2 && f3 != 3) send_rand(rv_decode_pkg::opc_branch, f3, -1);
			end
			send_rand(rv_decode_pkg::opc_jal, -1, -1);
			send_rand(rv_decode_pkg::opc_jalr, 0, -1);
			send_rand(rv_decode_pkg::opc_lui, -1, -1);
			send_rand(rv_decode_pkg::opc_auipc, -1, -1);
		end
		end_test("control");
	endtask

	task automatic trap_words();
		logic [31:0] w;
		int n;
		begin_test();
		send_word(32'h0010_0073);
		send_word(32'h0000_0073);
		repeat (4) begin
			w = $random(seed);
			n = 0;
			while (known_opcode(w[6:0]) && n < 100) begin
				w = $random(seed);
				n++;
			end
			send_word(w);
		end
		end_test("traps");
	endtask

	task automatic back_pressure();
		logic [31:0] w;
		int start;
		bit stalled;
		begin_test();
		start = recv_count;
		hold_ack <= 1'b1;
		// fifo plus the record held in the issue port
		for (int i = 0; i < fifo_depth + 1; i++) send_rand(rv_decode_pkg::opc_op_imm, 0, -1);
		if (!hung) begin
			w = $random(seed);
			w[6:0] = rv_decode_pkg::opc_lui;
			word_q.push_back(w);
			exp_q.push_back(decode_ref(w));
			test_words++;
			@(posedge clk_i);
			inst <= w;
			inst_req <= 1'b1;
			stalled = 1'b1;
			repeat (stall_cycles) begin
				@(posedge clk_i);
				if (inst_ack) stalled = 1'b0;
			end
			cur_word = w;
			check_val("inst_ack low while full", stalled, 1);
			hold_ack <= 1'b0;
			wait_ack(1'b1, "waiting for the acknowledge after release");
			inst_req <= 1'b0;
			wait_ack(1'b0, "waiting for the release");
		end
		drain("back-pressure");
		check_val("records out", recv_count - start, fifo_depth + 2);
		end_test("back-pressure");
	endtask

	initial begin
		int n;
		seed = 32'hefaa;
		n = 0;
		while (rst_n !== 1'b1 && n < timeout_cycles) begin
			@(posedge clk_i);
			n++;
		end
		if (rst_n !== 1'b1) begin
			$display("timeout: reset was never released");
			hung = 1'b1;
		end
		reg_reg_alu();
		imm_alu();
		memory_access();
		control_flow();
		trap_words();
		back_pressure();
		$display("tests %0d, records %0d, checks %0d, errors %0d", tests_run, recv_count,
			checks, errors);
		if (!hung && errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
	output logic clk_i,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period
	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk_i);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- rv_decode_top.sv
`default_nettype none

module rv_decode_top #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                      clk_i,
	input  logic                      rst_n,
	input  rv_decode_pkg::inst_word_u inst,
	input  logic                      inst_req,
	output logic                      inst_ack,
	output rv_decode_pkg::dec_op_t    op,
	output logic                      op_req,
	input  logic                      op_ack
);

	logic push;
	logic full;
	logic pop;
	logic empty;
	rv_decode_pkg::dec_op_t push_data;
	rv_decode_pkg::dec_op_t pop_data;

	rv_decode_stage u_decode_stage (
		.clk_i     (clk_i),
		.rst_n     (rst_n),
		.inst      (inst),
		.inst_req  (inst_req),
		.inst_ack  (inst_ack),
		.full      (full),
		.push      (push),
		.push_data (push_data)
	);

	rv_op_fifo #(
		.DEPTH (FIFO_DEPTH)
	) u_op_fifo (
		.clk_i     (clk_i),
		.rst_n     (rst_n),
		.push      (push),
		.push_data (push_data),
		.full      (full),
		.pop       (pop),
		.pop_data  (pop_data),
		.empty     (empty)
	);

	rv_issue_port u_issue_port (
		.clk_i    (clk_i),
		.rst_n    (rst_n),
		.empty    (empty),
		.pop_data (pop_data),
		.pop      (pop),
		.op       (op),
		.op_req   (op_req),
		.op_ack   (op_ack)
	);

endmodule

`default_nettype wire

//--- rv_issue_port.sv
`default_nettype none

module rv_issue_port (
	input  logic                   clk_i,
	input  logic                   rst_n,
	input  logic                   empty,
	input  rv_decode_pkg::dec_op_t pop_data,
	output logic                   pop,
	output rv_decode_pkg::dec_op_t op,
	output logic                   op_req,
	input  logic                   op_ack
);

	typedef enum logic [1:0] {st_idle, st_req, st_rel} issue_st_e;

	issue_st_e state;

	// next record only once the sink has dropped ack
	assign pop = (state == st_idle) && !empty;
	assign op_req = (state == st_req);

	always_ff @(posedge clk_i) begin
		if (pop) begin
			op <= pop_data;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: if (pop) state <= st_req;
				st_req: if (op_ack) state <= st_rel;
				st_rel: if (!op_ack) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rv_op_fifo.sv
`default_nettype none

module rv_op_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                   clk_i,
	input  logic                   rst_n,
	input  logic                   push,
	input  rv_decode_pkg::dec_op_t push_data,
	output logic                   full,
	input  logic                   pop,
	output rv_decode_pkg::dec_op_t pop_data,
	output logic                   empty
);

	localparam int AW = $clog2(DEPTH);

	rv_decode_pkg::dec_op_t mem [DEPTH];
	logic [AW:0] wptr;
	logic [AW:0] rptr;
	logic do_push;
	logic do_pop;

	// extra msb tells a wrapped writer from an equal reader
	assign empty = (wptr == rptr);
	assign full = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// show-ahead read
	assign pop_data = mem[rptr[AW-1:0]];

	always_ff @(posedge clk_i) begin
		if (do_push) begin
			mem[wptr[AW-1:0]] <= push_data;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (do_push) begin
				wptr <= wptr + 1'b1;
			end
			if (do_pop) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rv_decode_stage.sv
`default_nettype none

module rv_decode_stage (
	input  logic                       clk_i,
	input  logic                       rst_n,
	input  rv_decode_pkg::inst_word_u  inst,
	input  logic                       inst_req,
	output logic                       inst_ack,
	input  logic                       full,
	output logic                       push,
	output rv_decode_pkg::dec_op_t     push_data
);

	typedef enum logic {st_wait, st_ack} stage_st_e;

	stage_st_e state;
	rv_decode_pkg::imm_fmt_e fmt;
	logic [rv_decode_pkg::xlen-1:0] imm;

	rv_op_decoder u_op_decoder (
		.inst (inst),
		.imm  (imm),
		.fmt  (fmt),
		.dec  (push_data)
	);

	rv_imm_gen u_imm_gen (
		.inst (inst),
		.fmt  (fmt),
		.imm  (imm)
	);

	// accept only with room in the fifo, otherwise ack is held back
	assign push = (state == st_wait) && inst_req && !full;
	assign inst_ack = (state == st_ack);

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state <= st_wait;
		end else begin
			case (state)
				st_wait: if (push) state <= st_ack;
				st_ack: if (!inst_req) state <= st_wait;
				default: state <= st_wait;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rv_op_decoder.sv
`default_nettype none

module rv_op_decoder (
	input  rv_decode_pkg::inst_word_u           inst,
	input  logic [rv_decode_pkg::xlen-1:0]      imm,
	output rv_decode_pkg::imm_fmt_e             fmt,
	output rv_decode_pkg::dec_op_t              dec
);

	rv_decode_pkg::dec_op_t d;
	logic [6:0] f7;
	logic [2:0] f3;
	logic use_rs1;
	logic use_rs2;

	assign f7 = inst.r_view.funct7;
	assign f3 = inst.r_view.funct3;

	always_comb begin
		d = '0;
		fmt = rv_decode_pkg::fmt_none;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (inst.r_view.opcode)
			rv_decode_pkg::opc_op_imm: begin
				use_rs1 = 1'b1;
				d.rd_wen = 1'b1;
				d.alu_src_imm = 1'b1;
				d.wb_sel = rv_decode_pkg::wb_alu;
				fmt = rv_decode_pkg::fmt_i;
				case (f3)
					3'b000: d.alu_op = rv_decode_pkg::alu_add;
					3'b010: d.alu_op = rv_decode_pkg::alu_slt;
					3'b011: d.alu_op = rv_decode_pkg::alu_sltu;
					3'b100: d.alu_op = rv_decode_pkg::alu_xor;
					3'b110: d.alu_op = rv_decode_pkg::alu_or;
					3'b111: d.alu_op = rv_decode_pkg::alu_and;
					3'b001: begin
						d.alu_op = rv_decode_pkg::alu_sll;
						fmt = rv_decode_pkg::fmt_shamt;
						d.illegal = (f7 != 7'b0000000);
					end
					default: begin
						d.alu_op = f7[5] ? rv_decode_pkg::alu_sra : rv_decode_pkg::alu_srl;
						fmt = rv_decode_pkg::fmt_shamt;
						d.illegal = (f7 != 7'b0000000) && (f7 != 7'b0100000);
					end
				endcase
			end
			rv_decode_pkg::opc_op: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				d.rd_wen = 1'b1;
				d.wb_sel = rv_decode_pkg::wb_alu;
				case ({f7, f3})
					10'b0000000_000: d.alu_op = rv_decode_pkg::alu_add;
					10'b0100000_000: d.alu_op = rv_decode_pkg::alu_sub;
					10'b0000000_001: d.alu_op = rv_decode_pkg::alu_sll;
					10'b0000000_010: d.alu_op = rv_decode_pkg::alu_slt;
					10'b0000000_011: d.alu_op = rv_decode_pkg::alu_sltu;
					10'b0000000_100: d.alu_op = rv_decode_pkg::alu_xor;
					10'b0000000_101: d.alu_op = rv_decode_pkg::alu_srl;
					10'b0100000_101: d.alu_op = rv_decode_pkg::alu_sra;
					10'b0000000_110: d.alu_op = rv_decode_pkg::alu_or;
					10'b0000000_111: d.alu_op = rv_decode_pkg::alu_and;
					default: d.illegal = 1'b1;
				endcase
			end
			rv_decode_pkg::opc_load: begin
				use_rs1 = 1'b1;
				d.alu_src_imm = 1'b1;
				fmt = rv_decode_pkg::fmt_i;
				// lb lh lw lbu lhu only
				if (f3[1:0] == 2'b11 || f3[2:1] == 2'b11) begin
					d.illegal = 1'b1;
				end else begin
					d.rd_wen = 1'b1;
					d.mem_kind = rv_decode_pkg::mem_load;
					d.mem_size = rv_decode_pkg::mem_size_e'(f3[1:0]);
					d.mem_unsigned = f3[2];
					d.wb_sel = rv_decode_pkg::wb_mem;
				end
			end
			rv_decode_pkg::opc_store: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				d.alu_src_imm = 1'b1;
				fmt = rv_decode_pkg::fmt_s;
				if (f3[2] || f3[1:0] == 2'b11) begin
					d.illegal = 1'b1;
				end else begin
					d.mem_kind = rv_decode_pkg::mem_store;
					d.mem_size = rv_decode_pkg::mem_size_e'(f3[1:0]);
				end
			end
			rv_decode_pkg::opc_branch: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				fmt = rv_decode_pkg::fmt_b;
				// compare op for the alu, target is pc plus imm
				case (f3[2:1])
					2'b00: d.alu_op = rv_decode_pkg::alu_sub;
					2'b10: d.alu_op = rv_decode_pkg::alu_slt;
					2'b11: d.alu_op = rv_decode_pkg::alu_sltu;
					default: d.illegal = 1'b1;
				endcase
				case (f3)
					3'b000: d.br_cond = rv_decode_pkg::br_eq;
					3'b001: d.br_cond = rv_decode_pkg::br_ne;
					3'b100: d.br_cond = rv_decode_pkg::br_lt;
					3'b101: d.br_cond = rv_decode_pkg::br_ge;
					3'b110: d.br_cond = rv_decode_pkg::br_ltu;
					3'b111: d.br_cond = rv_decode_pkg::br_geu;
					default: d.br_cond = rv_decode_pkg::br_none;
				endcase
			end
			rv_decode_pkg::opc_jal: begin
				d.rd_wen = 1'b1;
				d.jump = rv_decode_pkg::jump_jal;
				d.wb_sel = rv_decode_pkg::wb_pc4;
				fmt = rv_decode_pkg::fmt_j;
			end
			rv_decode_pkg::opc_jalr: begin
				use_rs1 = 1'b1;
				d.alu_src_imm = 1'b1;
				fmt = rv_decode_pkg::fmt_i;
				if (f3 != 3'b000) begin
					d.illegal = 1'b1;
				end else begin
					d.rd_wen = 1'b1;
					d.jump = rv_decode_pkg::jump_jalr;
					d.wb_sel = rv_decode_pkg::wb_pc4;
				end
			end
			rv_decode_pkg::opc_lui: begin
				d.rd_wen = 1'b1;
				d.wb_sel = rv_decode_pkg::wb_imm;
				fmt = rv_decode_pkg::fmt_u;
			end
			rv_decode_pkg::opc_auipc: begin
				d.rd_wen = 1'b1;
				d.wb_sel = rv_decode_pkg::wb_pc_imm;
				fmt = rv_decode_pkg::fmt_u;
			end
			rv_decode_pkg::opc_system: begin
				// ebreak only, ecall and csr ops are not supported
				if (inst == 32'h0010_0073) begin
					d.trap = 1'b1;
				end else begin
					d.illegal = 1'b1;
				end
			end
			default: d.illegal = 1'b1;
		endcase
		if (d.illegal) begin
			d.rd_wen = 1'b0;
		end
		d.rs1 = use_rs1 ? inst.r_view.rs1 : '0;
		d.rs2 = use_rs2 ? inst.r_view.rs2 : '0;
		d.rd = d.rd_wen ? inst.r_view.rd : '0;
	end

	// immediate comes back from the generator for the selected format
	always_comb begin
		dec = d;
		dec.imm = imm;
	end

endmodule

`default_nettype wire

//--- rv_imm_gen.sv
`default_nettype none

module rv_imm_gen (
	input  rv_decode_pkg::inst_word_u      inst,
	input  rv_decode_pkg::imm_fmt_e        fmt,
	output logic [rv_decode_pkg::xlen-1:0] imm
);

	localparam int w = rv_decode_pkg::xlen;

	rv_decode_pkg::i_fmt_t iw;
	rv_decode_pkg::s_fmt_t sw;

	assign iw = inst.i_view;
	assign sw = inst.s_view;

	always_comb begin
		case (fmt)
			rv_decode_pkg::fmt_i: imm = {{(w-12){iw.imm12[11]}}, iw.imm12};
			rv_decode_pkg::fmt_s: imm = {{(w-12){sw.imm_hi[6]}}, sw.imm_hi, sw.imm_lo};
			rv_decode_pkg::fmt_b: begin
				imm = {{(w-12){sw.imm_hi[6]}}, sw.imm_lo[0], sw.imm_hi[5:0],
					sw.imm_lo[4:1], 1'b0};
			end
			rv_decode_pkg::fmt_u: imm = {iw.imm12, iw.rs1, iw.funct3, 12'b0};
			rv_decode_pkg::fmt_j: begin
				imm = {{(w-20){iw.imm12[11]}}, iw.rs1, iw.funct3, iw.imm12[0],
					iw.imm12[10:1], 1'b0};
			end
			// shamt is never sign extended
			rv_decode_pkg::fmt_shamt: imm = {{(w-6){1'b0}}, iw.imm12[5:0]};
			default: imm = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

	localparam int xlen = 32;

	typedef logic [4:0] reg_addr_t;

	// rv32i major opcodes
	typedef enum logic [6:0] {
		opc_load   = 7'b0000011,
		opc_op_imm = 7'b0010011,
		opc_auipc  = 7'b0010111,
		opc_store  = 7'b0100011,
		opc_op     = 7'b0110011,
		opc_lui    = 7'b0110111,
		opc_branch = 7'b1100011,
		opc_jalr   = 7'b1100111,
		opc_jal    = 7'b1101111,
		opc_system = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		fmt_none, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j, fmt_shamt
	} imm_fmt_e;

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// shared by stores and branches
	typedef struct packed {
		logic [6:0] imm_hi;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef union packed {
		r_fmt_t r_view;
		i_fmt_t i_view;
		s_fmt_t s_view;
	} inst_word_u;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
		alu_xor, alu_srl, alu_sra, alu_or, alu_and
	} alu_op_e;

	typedef enum logic [1:0] {mem_none, mem_load, mem_store} mem_kind_e;

	// same encoding as funct3[1:0] of loads and stores
	typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_e;

	typedef enum logic [2:0] {
		br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu
	} br_cond_e;

	typedef enum logic [1:0] {jump_none, jump_jal, jump_jalr} jump_e;

	typedef enum logic [2:0] {
		wb_none, wb_alu, wb_mem, wb_pc4, wb_imm, wb_pc_imm
	} wb_sel_e;

	typedef struct packed {
		reg_addr_t       rs1;
		reg_addr_t       rs2;
		reg_addr_t       rd;
		logic            rd_wen;
		alu_op_e         alu_op;
		logic            alu_src_imm;
		logic [xlen-1:0] imm;
		mem_kind_e       mem_kind;
		mem_size_e       mem_size;
		logic            mem_unsigned;
		br_cond_e        br_cond;
		jump_e           jump;
		wb_sel_e         wb_sel;
		logic            trap;
		logic            illegal;
	} dec_op_t;

endpackage

`default_nettype wire
